//--- verilog/z80BusPkg.sv
`default_nettype none

package z80BusPkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int addrWidth    = 16;   // Z80 address bus
    localparam int dataWidth    = 8;    // Z80 data bus
    localparam int kindWidth    = 3;    // Cycle-kind code
    localparam int refreshWidth = 7;    // R register low bits put out in refresh

    // --------------------------------------------------
    // Cycle-kind codes
    // --------------------------------------------------
    localparam logic [kindWidth-1:0] kindFetch    = 3'd0;  // Opcode fetch, M1 cycle
    localparam logic [kindWidth-1:0] kindMemRead  = 3'd1;
    localparam logic [kindWidth-1:0] kindMemWrite = 3'd2;
    localparam logic [kindWidth-1:0] kindIoRead   = 3'd3;  // One automatic wait state
    localparam logic [kindWidth-1:0] kindIoWrite  = 3'd4;
    localparam logic [kindWidth-1:0] kindIntAck   = 3'd5;  // M1 with two wait states

endpackage

`default_nettype wire

//--- verilog/busIfs.sv
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// Command path from the FIFO head to the sequencer
// --------------------------------------------------
interface cmdIf import z80BusPkg::*; ();
    logic                 valid;    // Head holds a command
    logic                 ready;    // Sequencer takes it, idle only
    logic [kindWidth-1:0] kind;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] data;     // Write data, unused for reads

    modport src (output valid, kind, addr, data, input ready);
    modport dst (input valid, kind, addr, data, output ready);
endinterface

// --------------------------------------------------
// T-state and function flags toward the pin decoder
// --------------------------------------------------
interface tStateIf;
    // One-hot T-states, all low when idle
    logic t1, t2, tw1, tw2, t3, t4;

    // Function of the running cycle
    logic fFetch;       // Also set for interrupt acknowledge
    logic fMRead;
    logic fMWrite;
    logic fIoRead;
    logic fIoWrite;
    logic inIntr;       // Interrupt acknowledge variant of fetch

    logic holdBus;      // Bus handed over by BUSACK

    modport drv (output t1, t2, tw1, tw2, t3, t4,
                 output fFetch, fMRead, fMWrite, fIoRead, fIoWrite, inIntr,
                 output holdBus);
    modport rcv (input t1, t2, tw1, tw2, t3, t4,
                 input fFetch, fMRead, fMWrite, fIoRead, fIoWrite, inIntr,
                 input holdBus);
endinterface

`default_nettype wire

//--- verilog/cmdFifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmdFifo import z80BusPkg::*; #(
    parameter int fifoDepth = 4
) (
    input  wire logic                 setM1,
    input  wire logic                 rstN,
    input  wire logic                 inValid,
    output logic                      inReady,
    input  wire logic [kindWidth-1:0] inKind,
    input  wire logic [addrWidth-1:0] inAddr,
    input  wire logic [dataWidth-1:0] inData,
    cmdIf.src                         cmd
);

    localparam int ptrWidth = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
    localparam int cntWidth = $clog2(fifoDepth + 1);

    // Storage, one entry per command
    logic [kindWidth-1:0] kindMem [fifoDepth];
    logic [addrWidth-1:0] addrMem [fifoDepth];
    logic [dataWidth-1:0] dataMem [fifoDepth];

    logic [ptrWidth-1:0] wrPtr, rdPtr;
    logic [cntWidth-1:0] count;
    logic                doPush, doPop;

    assign inReady = (count != cntWidth'(fifoDepth));   // Only back-pressure source
    assign doPush  = inValid & inReady;
    assign doPop   = cmd.valid & cmd.ready;

    // Head straight out of the array
    assign cmd.valid = (count != '0);
    assign cmd.kind  = kindMem[rdPtr];
    assign cmd.addr  = addrMem[rdPtr];
    assign cmd.data  = dataMem[rdPtr];

    always_ff @(posedge setM1) begin
        if (doPush) begin
            kindMem[wrPtr] <= inKind;
            addrMem[wrPtr] <= inAddr;
            dataMem[wrPtr] <= inData;
        end
    end

    // --------------------------------------------------
    // Pointers and fill level
    // --------------------------------------------------
    always_ff @(posedge setM1 or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush)     // Wrap by compare, depth need not be a power of two
                wrPtr <= (wrPtr == ptrWidth'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == ptrWidth'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            if (doPush && !doPop)
                count <= count + 1'b1;
            else if (doPop && !doPush)
                count <= count - 1'b1;
        end
    end

    // Fill level never runs past full or below empty
    assert property (@(posedge setM1) disable iff (!rstN)
        count <= cntWidth'(fifoDepth));

    // Pointers meet when empty or full
    assert property (@(posedge setM1) disable iff (!rstN)
        (count == '0 || count == cntWidth'(fifoDepth)) |-> wrPtr == rdPtr);

endmodule

`default_nettype wire

//--- verilog/busCycleSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module busCycleSequencer import z80BusPkg::*; (
    input  wire logic                 setM1,
    input  wire logic                 rstN,
    cmdIf.dst                         cmd,
    tStateIf.drv                      ts,
    input  wire logic                 waitReq,    // WAIT, active high here
    input  wire logic                 busReq,     // BUSRQ, active high here
    input  wire logic [dataWidth-1:0] dataIn,
    output logic                      busack,
    output logic [addrWidth-1:0]      addrBus,
    output logic [dataWidth-1:0]      dataOut,
    output logic                      rspValid,
    output logic [dataWidth-1:0]      rspData
);

    logic [addrWidth-1:0]    addrReg;
    logic [dataWidth-1:0]    dataReg;
    logic [refreshWidth-1:0] refreshCnt;     // Low bits of R

    logic idle, lastState, sampleState, stall, doPop;
    logic isIo, isRead;

    // --------------------------------------------------
    // State qualifiers
    // --------------------------------------------------
    assign idle      = ~(ts.t1 | ts.t2 | ts.tw1 | ts.tw2 | ts.t3 | ts.t4);
    assign isIo      = ts.fIoRead | ts.fIoWrite;
    assign isRead    = ts.fFetch | ts.fMRead | ts.fIoRead;   // Cycles that answer
    assign lastState = (ts.t3 & ~ts.fFetch) | ts.t4;          // Fetch runs on to T4

    // WAIT is looked at in one state per kind
    assign sampleState = (ts.t2  & (ts.fMRead | ts.fMWrite | (ts.fFetch & ~ts.inIntr))) |
                         (ts.tw1 & isIo) |
                         (ts.tw2 & ts.inIntr);
    assign stall = sampleState & waitReq;

    // Pop only from a free idle cycle
    assign cmd.ready = idle & ~ts.holdBus & ~busReq;
    assign doPop     = cmd.valid & cmd.ready;

    assign busack = ts.holdBus;

    // Refresh address over the low bits in T3 and T4 of an M1 cycle
    assign addrBus = (ts.fFetch & (ts.t3 | ts.t4)) ?
                     {addrReg[addrWidth-1:refreshWidth], refreshCnt} : addrReg;
    assign dataOut = dataReg;

    // --------------------------------------------------
    // T-state machine and bus release
    // --------------------------------------------------
    always_ff @(posedge setM1 or negedge rstN) begin
        if (!rstN) begin
            ts.t1       <= 1'b0;
            ts.t2       <= 1'b0;
            ts.tw1      <= 1'b0;
            ts.tw2      <= 1'b0;
            ts.t3       <= 1'b0;
            ts.t4       <= 1'b0;
            ts.fFetch   <= 1'b0;
            ts.fMRead   <= 1'b0;
            ts.fMWrite  <= 1'b0;
            ts.fIoRead  <= 1'b0;
            ts.fIoWrite <= 1'b0;
            ts.inIntr   <= 1'b0;
            ts.holdBus  <= 1'b0;
            rspValid    <= 1'b0;
            refreshCnt  <= '0;
        end else begin
            rspValid <= lastState & isRead;           // One pulse after the last state
            if (lastState | idle)
                ts.holdBus <= busReq;                 // BUSACK trails BUSRQ by one clock
            if (!stall) begin                         // Waits freeze the state
                ts.t1  <= doPop;
                ts.t2  <= ts.t1;
                ts.tw1 <= ts.t2 & (isIo | ts.inIntr);
                ts.tw2 <= ts.tw1 & ts.inIntr;
                ts.t3  <= (ts.t2 & ~(isIo | ts.inIntr)) | (ts.tw1 & isIo) | ts.tw2;
                ts.t4  <= ts.t3 & ts.fFetch;
            end
            if (doPop) begin
                ts.fFetch   <= (cmd.kind == kindFetch) || (cmd.kind == kindIntAck);
                ts.fMRead   <= (cmd.kind == kindMemRead);
                ts.fMWrite  <= (cmd.kind == kindMemWrite);
                ts.fIoRead  <= (cmd.kind == kindIoRead);
                ts.fIoWrite <= (cmd.kind == kindIoWrite);
                ts.inIntr   <= (cmd.kind == kindIntAck);
            end
            if (ts.t4)
                refreshCnt <= refreshCnt + 1'b1;      // Once per fetch or acknowledge
        end
    end

    // Command payload and read data
    always_ff @(posedge setM1) begin
        if (doPop) begin
            addrReg <= cmd.addr;
            dataReg <= cmd.data;
        end
        if (sampleState & ~waitReq & isRead)
            rspData <= dataIn;                        // Clock that ends the wait
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    assert property (@(posedge setM1) disable iff (!rstN)
        $onehot0({ts.t1, ts.t2, ts.tw1, ts.tw2, ts.t3, ts.t4}));

    // A released bus never starts a cycle from the FIFO
    assert property (@(posedge setM1) disable iff (!rstN)
        ts.holdBus |=> idle);

endmodule

`default_nettype wire

//--- verilog/pinControl.sv
`timescale 1ns/1ps
`default_nettype none

module pinControl (
    input  wire logic setM1,
    input  wire logic rstN,
    tStateIf.rcv      ts,
    output logic      m1,       // M1
    output logic      mreq,     // MREQ
    output logic      iorq,     // IORQ
    output logic      rd,       // RD
    output logic      wr,       // WR
    output logic      rfsh,     // RFSH
    output logic      addrOe,   // Address pads drive
    output logic      addrWe,   // Address pad latch load
    output logic      dataOe    // Data pads drive
);

    // One-clock delayed T-state copies
    logic t1Dly, t2Dly, t3Dly;

    logic fetchOp, intAck, ioCyc, ioPhase, busy, own;

    always_ff @(posedge setM1 or negedge rstN) begin
        if (!rstN) begin
            t1Dly  <= 1'b0;
            t2Dly  <= 1'b0;
            t3Dly  <= 1'b0;
        end else begin
            t1Dly  <= ts.t1;
            t2Dly  <= ts.t2;        // Also high through stretched T2
            t3Dly  <= ts.t3;
        end
    end

    assign fetchOp = ts.fFetch & ~ts.inIntr;            // Plain opcode fetch
    assign intAck  = ts.fFetch & ts.inIntr;
    assign ioCyc   = ts.fIoRead | ts.fIoWrite;
    assign ioPhase = ts.t2 | ts.tw1 | ts.t3;            // I/O strobe window
    assign busy    = ts.t1 | ts.t2 | ts.tw1 | ts.tw2 | ts.t3 | ts.t4;

    // Everything drops while BUSACK is up
    assign own = ~ts.holdBus;

    // --------------------------------------------------
    // Control pins
    // --------------------------------------------------
    assign m1   = own & ((fetchOp & (ts.t1 | ts.t2)) |
                         (intAck  & (ts.t1 | ts.t2 | ts.tw1 | ts.tw2)));

    // Opcode strobe in T1-T2, refresh strobe in T4
    assign mreq = own & ((fetchOp & (ts.t1 | ts.t2)) |
                         (ts.fFetch & t3Dly) |
                         (ts.fMRead  & (ts.t1 | ts.t2 | ts.t3)) |
                         (ts.fMWrite & (ts.t1 | ts.t2 | ts.t3)));

    // IORQ through both wait states of an acknowledge
    assign iorq = own & ((intAck & (ts.tw1 | ts.tw2)) |
                         (ioCyc  & ioPhase));

    assign rd   = own & ((fetchOp    & (ts.t1 | ts.t2)) |
                         (ts.fMRead  & (ts.t1 | ts.t2 | ts.t3)) |
                         (ts.fIoRead & ioPhase));

    // Memory WR starts one clock into T2, data is settled by then
    assign wr   = own & ((ts.fMWrite  & t2Dly) |
                         (ts.fIoWrite & ioPhase));

    assign rfsh = own & ts.fFetch & (ts.t3 | ts.t4);

    // --------------------------------------------------
    // Pad enables
    // --------------------------------------------------
    assign addrOe = own & busy;

    // New address in T1, refresh address in T3 of M1
    assign addrWe = own & (ts.t1 | (ts.fFetch & ts.t3));

    assign dataOe = own & ((ts.fMWrite  & (t1Dly | t2Dly)) |   // T2 through T3
                           (ts.fIoWrite & ioPhase));

endmodule

`default_nettype wire

//--- verilog/z80BusUnit.sv
`timescale 1ns/1ps
`default_nettype none

module z80BusUnit import z80BusPkg::*; #(
    parameter int fifoDepth = 4
) (
    input  wire logic                 setM1,
    input  wire logic                 rstN,

    // Command port
    input  wire logic                 cmdValid,
    output logic                      cmdReady,
    input  wire logic [kindWidth-1:0] cmdKind,
    input  wire logic [addrWidth-1:0] cmdAddr,
    input  wire logic [dataWidth-1:0] cmdData,

    // Bus pads, values plus enables
    output logic [addrWidth-1:0]      addrBus,
    output logic                      addrOe,
    output logic                      addrWe,
    output logic [dataWidth-1:0]      dataOut,
    output logic                      dataOe,
    input  wire logic [dataWidth-1:0] dataIn,

    // Control pins, active high
    output logic                      m1,
    output logic                      mreq,
    output logic                      iorq,
    output logic                      rd,
    output logic                      wr,
    output logic                      rfsh,
    output logic                      busack,
    input  wire logic                 waitReq,
    input  wire logic                 busReq,

    // Read response
    output logic                      rspValid,
    output logic [dataWidth-1:0]      rspData
);

    cmdIf    cmdBus ();
    tStateIf tState ();

    // --------------------------------------------------
    // Command queue
    // --------------------------------------------------
    cmdFifo #(
        .fifoDepth (fifoDepth)
    ) uCmdFifo (
        .setM1   (setM1),
        .rstN    (rstN),
        .inValid (cmdValid),
        .inReady (cmdReady),
        .inKind  (cmdKind),
        .inAddr  (cmdAddr),
        .inData  (cmdData),
        .cmd     (cmdBus.src)
    );

    // --------------------------------------------------
    // T-state sequencer
    // --------------------------------------------------
    busCycleSequencer uSequencer (
        .setM1    (setM1),
        .rstN     (rstN),
        .cmd      (cmdBus.dst),
        .ts       (tState.drv),
        .waitReq  (waitReq),
        .busReq   (busReq),
        .dataIn   (dataIn),
        .busack   (busack),
        .addrBus  (addrBus),
        .dataOut  (dataOut),
        .rspValid (rspValid),
        .rspData  (rspData)
    );

    // --------------------------------------------------
    // Pin decode
    // --------------------------------------------------
    pinControl uPinControl (
        .setM1  (setM1),
        .rstN   (rstN),
        .ts     (tState.rcv),
        .m1     (m1),
        .mreq   (mreq),
        .iorq   (iorq),
        .rd     (rd),
        .wr     (wr),
        .rfsh   (rfsh),
        .addrOe (addrOe),
        .addrWe (addrWe),
        .dataOe (dataOe)
    );

endmodule

`default_nettype wire

//--- verification/z80BusTests.svh
`ifndef z80BusTestsSvh
`define z80BusTestsSvh

// --------------------------------------------------
// Directed tests
// --------------------------------------------------

// Memory write, then read of the same byte
task automatic memWriteRead();
    logic [dataWidth-1:0] wData;
    wData = dataWidth'($urandom());
    pushCmd(kindMemWrite, 16'h1234, wData);
    watchCycle(0);
    checkEq("write cycle clocks", cycLen, 3);           // T1 T2 T3
    checkEq("mreq in write", mreqTr, 32'b111);
    checkEq("wr in write", wrTr, 32'b100);              // Delayed T2 up to T3
    checkEq("rd in write", rdTr, 0);
    checkEq("addrWe in write", weTr, 32'b001);          // Address latched in T1
    checkEq("dataOe in write", oeTr, 32'b110);
    checkEq("addrBus at wr", wrAddr, 16'h1234);
    checkEq("rspValid after write", gotRsp, 0);
    checkEq("memory byte written", mem[16'h1234], wData);
    pushCmd(kindMemRead, 16'h1234, 8'h00);
    watchCycle(0);
    checkEq("rd in read", rdTr, 32'b111);
    checkEq("dataOe in read", oeTr, 0);
    checkEq("rspValid after read", gotRsp, 1);
    checkEq("rspData after read", rspByte, wData);
endtask

// Two fetches, refresh address steps by one
task automatic opcodeFetch();
    logic [refreshWidth-1:0] firstRef;
    pushCmd(kindFetch, 16'h0300, 8'h00);
    watchCycle(0);
    checkEq("fetch cycle clocks", cycLen, 4);
    checkEq("m1 in fetch", m1Tr, 32'b0011);             // T1 and T2 only
    checkEq("rfsh in fetch", rfshTr, 32'b1100);         // T3 and T4
    checkEq("addrWe in fetch", weTr, 32'b0101);         // Opcode and refresh address
    checkEq("rspValid after fetch", gotRsp, 1);
    checkEq("rspData after fetch", rspByte, fillByte(16'h0300));
    firstRef = refLow;
    pushCmd(kindFetch, 16'h0301, 8'h00);
    watchCycle(0);
    checkEq("refresh address step", refLow, refreshWidth'(firstRef + 1'b1));
    checkEq("rspData after second fetch", rspByte, fillByte(16'h0301));
endtask

// Interrupt acknowledge, IORQ in the two wait states
task automatic intAckCycle();
    pushCmd(kindIntAck, 16'h0038, 8'h00);
    watchCycle(0);
    checkEq("acknowledge clocks", cycLen, 6);           // T1 T2 Tw1 Tw2 T3 T4
    checkEq("iorq in acknowledge", iorqTr, 32'b001100);
    checkEq("rd in acknowledge", rdTr, 0);
    checkEq("rspValid after acknowledge", gotRsp, 1);
    checkEq("rspData after acknowledge", rspByte, 8'hFF);   // No vector on the bus
endtask

task automatic ioReadWrite();
    logic [dataWidth-1:0] wData;
    wData = dataWidth'($urandom());
    pushCmd(kindIoWrite, 16'h0042, wData);
    watchCycle(0);
    checkEq("I/O write clocks", cycLen, 4);             // One automatic wait
    checkEq("iorq in I/O write", iorqTr, 32'b1110);
    checkEq("wr in I/O write", wrTr, 32'b1110);
    checkEq("dataOe in I/O write", oeTr, 32'b1110);
    checkEq("mreq in I/O write", mreqTr, 0);
    checkEq("m1 in I/O write", m1Tr, 0);
    checkEq("I/O byte written", ioMem[8'h42], wData);
    pushCmd(kindIoRead, 16'h0042, 8'h00);
    watchCycle(0);
    checkEq("iorq in I/O read", iorqTr, 32'b1110);
    checkEq("rd in I/O read", rdTr, 32'b1110);
    checkEq("mreq in I/O read", mreqTr, 0);
    checkEq("m1 in I/O read", m1Tr, 0);
    checkEq("rspValid after I/O read", gotRsp, 1);
    checkEq("rspData after I/O read", rspByte, wData);
endtask

// Each high WAIT sample adds one clock to mreq
task automatic waitInsertion();
    int n;
    for (n = 0; n <= 3; n++) begin
        pushCmd(kindMemRead, 16'h2345 + 16'(n), 8'h00);
        watchCycle(n);
        checkEq("mreq clocks with WAIT", $countones(mreqTr), 3 + n);
        checkEq("read clocks with WAIT", cycLen, 3 + n);
        checkEq("rspValid with WAIT", gotRsp, 1);
        checkEq("rspData with WAIT", rspByte, fillByte(16'h2345 + 16'(n)));
    end
endtask

task automatic busRelease();
    int n;
    pushCmd(kindMemRead, 16'h2400, 8'h00);
    waitActive();
    busReq = 1'b1;                                      // Raised in T1
    checkEq("busack inside cycle", busack, 0);
    finishCycle(0);
    checkEq("cycle clocks under busReq", cycLen, 3);
    checkEq("busack after cycle end", busack, 1);
    checkEq("rspData before release", rspByte, fillByte(16'h2400));
    pushCmd(kindMemRead, 16'h2401, 8'h00);              // Queued while held
    pushCmd(kindMemRead, 16'h2402, 8'h00);
    for (n = 0; n < 6; n++) begin
        checkEq("busack while held", busack, 1);
        checkEq("pins while held", {addrOe, m1, mreq, iorq, rd, wr, rfsh}, 0);
        @(negedge setM1);
    end
    busReq = 1'b0;
    @(negedge setM1);
    checkEq("busack after busReq low", busack, 0);
    for (n = 1; n <= 2; n++) begin
        watchCycle(0);
        checkEq("queued read order", rspByte, fillByte(16'h2400 + 16'(n)));
    end
endtask

// FIFO fills up behind a stalled read
task automatic fifoBackPressure();
    int n;
    waitReq = 1'b1;
    pushCmd(kindMemRead, 16'h2500, 8'h00);
    for (n = 0; n < fifoDepth; n++)
        pushCmd(kindMemRead, 16'h2510 + 16'(n), 8'h00);
    for (n = 0; n < 5; n++) begin
        checkEq("cmdReady with full FIFO", cmdReady, 0);
        checkEq("stalled cycle still active", addrOe, 1);
        @(negedge setM1);
    end
    waitReq = 1'b0;
    watchCycle(0);
    checkEq("rspData of stalled read", rspByte, fillByte(16'h2500));
    for (n = 0; n < fifoDepth; n++) begin
        watchCycle(0);
        checkEq("rspValid of queued read", gotRsp, 1);
        checkEq("queued read order", rspByte, fillByte(16'h2510 + 16'(n)));
    end
endtask

`endif

//--- verification/z80BusTb.sv
`timescale 1ns/1ps
`default_nettype none

module z80BusTb import z80BusPkg::*; ();

    localparam int fifoDepth = 4;
    localparam int maxWait   = 40;      // Clocks any one wait loop may take

    logic                    setM1 = 1'b0;      // First rising edge at 50 ns
    logic                    rstN;
    logic                    cmdValid, cmdReady;
    logic [kindWidth-1:0]    cmdKind;
    logic [addrWidth-1:0]    cmdAddr;
    logic [dataWidth-1:0]    cmdData;
    logic [addrWidth-1:0]    addrBus;
    logic [dataWidth-1:0]    dataOut, rspData;
    logic [dataWidth-1:0]    dataIn = 8'hFF;     // Idle bus reads as FF
    logic                    addrOe, addrWe, dataOe, m1, mreq, iorq, rd, wr, rfsh, busack;
    logic                    waitReq, busReq, rspValid;

    // Memory and I/O space of the model
    logic [dataWidth-1:0]    mem   [1 << addrWidth];
    logic [dataWidth-1:0]    ioMem [256];

    // Last watched bus cycle, bit i is active clock i
    logic [31:0]             m1Tr, mreqTr, rdTr, wrTr, iorqTr, rfshTr, weTr, oeTr;
    int                      cycLen;
    logic                    gotRsp;
    logic [dataWidth-1:0]    rspByte;
    logic [addrWidth-1:0]    wrAddr;            // addrBus while wr is high
    logic [refreshWidth-1:0] refLow;            // Low address bits at first rfsh clock

    z80BusUnit #(.fifoDepth(fifoDepth)) dut_i (.*);

    initial begin
        forever #50 setM1 = ~setM1;             // 100 ns period
    end

    // Fill byte, every address bit counts
    function automatic logic [dataWidth-1:0] fillByte(input logic [addrWidth-1:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    // --------------------------------------------------
    // Memory and I/O model
    // --------------------------------------------------
    initial begin
        for (int a = 0; a < (1 << addrWidth); a++)
            mem[a] = fillByte(addrWidth'(a));
        for (int p = 0; p < 256; p++)
            ioMem[p] = 8'(p) ^ 8'hA5;
    end

    always @(negedge setM1) begin
        if (mreq && rd)
            dataIn <= mem[addrBus];
        else if (iorq && rd)
            dataIn <= ioMem[addrBus[7:0]];      // 8-bit port number
        else
            dataIn <= 8'hFF;
        if (mreq && wr && dataOe)
            mem[addrBus] <= dataOut;
        if (iorq && wr && dataOe)
            ioMem[addrBus[7:0]] <= dataOut;
    end

    // --------------------------------------------------
    // Checks and run control
    // --------------------------------------------------
    task automatic stopRun();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic abortRun(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stopRun();
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            stopRun();
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the push
    task automatic pushCmd(input logic [kindWidth-1:0] kind, input logic [addrWidth-1:0] addr,
                           input logic [dataWidth-1:0] data);
        int n;
        n = 0;
        while (!cmdReady) begin
            if (n == maxWait)
                abortRun("command port never became ready");
            n++;
            @(negedge setM1);
        end
        cmdValid = 1'b1;
        cmdKind  = kind;
        cmdAddr  = addr;
        cmdData  = data;
        @(negedge setM1);
        cmdValid = 1'b0;
    endtask

    task automatic waitActive();
        int n;
        n = 0;
        @(negedge setM1);
        while (!addrOe) begin                   // addrOe marks a running cycle
            if (n == maxWait)
                abortRun("no bus cycle started");
            n++;
            @(negedge setM1);
        end
    endtask

    // Trace one cycle from its current clock, WAIT held for waitLen T2 samples
    task automatic finishCycle(input int waitLen);
        int idx;
        idx    = 0;
        m1Tr   = '0;
        mreqTr = '0;
        rdTr   = '0;
        wrTr   = '0;
        iorqTr = '0;
        rfshTr = '0;
        weTr   = '0;
        oeTr   = '0;
        while (addrOe) begin
            if (idx == 32)
                abortRun("bus cycle did not end");
            if (rfsh && rfshTr == 0)
                refLow = addrBus[refreshWidth-1:0];
            if (wr)
                wrAddr = addrBus;
            m1Tr[idx]   = m1;
            mreqTr[idx] = mreq;
            rdTr[idx]   = rd;
            wrTr[idx]   = wr;
            iorqTr[idx] = iorq;
            rfshTr[idx] = rfsh;
            weTr[idx]   = addrWe;
            oeTr[idx]   = dataOe;
            if (waitLen > 0 && idx == 0)
                waitReq = 1'b1;                 // Seen from T2 onward
            if (waitLen > 0 && idx == waitLen + 1)
                waitReq = 1'b0;
            idx++;
            @(negedge setM1);
        end
        cycLen  = idx;
        gotRsp  = rspValid;                     // Pulse lands on the first idle clock
        rspByte = rspData;
    endtask

    task automatic watchCycle(input int waitLen);
        waitActive();
        finishCycle(waitLen);
    endtask

    `include "z80BusTests.svh"

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h7879));
        rstN     = 1'b0;
        cmdValid = 1'b0;
        cmdKind  = '0;
        cmdAddr  = '0;
        cmdData  = '0;
        waitReq  = 1'b0;
        busReq   = 1'b0;
        repeat (2) @(negedge setM1);
        rstN = 1'b1;
        checkEq("cmdReady after reset", cmdReady, 1);
        checkEq("control pins after reset",
                {m1, mreq, iorq, rd, wr, rfsh, busack, addrOe, dataOe, rspValid}, 0);

        memWriteRead();
        opcodeFetch();
        intAckCycle();
        ioReadWrite();
        waitInsertion();
        busRelease();
        fifoBackPressure();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+verification
verilog/z80BusPkg.sv
verilog/busIfs.sv
verilog/cmdFifo.sv
verilog/busCycleSequencer.sv
verilog/pinControl.sv
verilog/z80BusUnit.sv
verification/z80BusTb.sv

//--- run.sh
#!/bin/sh
# Build and run the z80BusUnit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module z80BusTb \
    -f project.f

# The pass line in the output decides the result
out=$(./obj_dir/Vz80BusTb 2>&1) || true
echo "$out"

if echo "$out" | grep -qF "=== PASS ==="; then
    exit 0
fi
exit 1
